// ==== tests/timer_cases.txt ====
# op offset data expected test, all hex but test; ops: 0 wr, 1 rd, 2 wait, 3 rtc, 4 irq
# 5 wr rand, 6 rd rand masked, 7 mark, 8 delta lo hi, 9 bad wr width, a rd range lo hi
0 00 fffffffe 00000000 1
1 00 00000000 00000002 1
0 04 ffffffff 00000000 1
1 04 00000000 000003ff 1
5 10 00000000 00000000 1
6 10 00000000 ffffffff 1
5 14 00000000 00000000 1
6 14 00000000 ffffffff 1
0 00 00000000 00000000 2
0 08 12345678 00000000 2
0 0c 00000abc 00000000 2
1 08 00000000 12345678 2
1 0c 00000000 00000abc 2
0 04 00000003 00000000 2
0 00 00000001 00000000 2
7 08 00000000 00000000 2
2 00 00000028 00000000 2
8 08 00000008 0000000c 2
0 00 00000000 00000000 3
0 08 ffffffff 00000000 3
0 0c 00000007 00000000 3
0 04 00000000 00000000 3
0 00 00000001 00000000 3
2 00 00000005 00000000 3
0 00 00000000 00000000 3
1 0c 00000000 00000008 3
a 08 00000000 00000020 3
0 10 00000000 00000000 4
0 14 00000009 00000000 4
4 00 00000000 00000000 4
0 0c 00000009 00000000 4
2 00 00000002 00000000 4
4 00 00000000 00000001 4
0 14 0000000a 00000000 4
4 00 00000000 00000000 4
9 08 00000001 00000000 5
9 0a 00000002 00000000 5
9 18 00000002 00000000 5
1 0c 00000000 00000009 5
1 00 00000000 00000000 5
0 00 00000003 00000000 6
7 08 00000000 00000000 6
2 00 0000001e 00000000 6
8 08 00000000 00000000 6
7 08 00000000 00000000 6
3 00 00000001 00000000 6
2 00 00000046 00000000 6
3 00 00000000 00000000 6
2 00 0000000a 00000000 6
8 08 00000009 0000000b 6

// ==== compile.f ====
+incdir+common
common/timer_pkg.sv
timer_ctrl/timer_ctrl.sv
verilog/timer_tick_gen.sv
verilog/timer_mtime.sv
verilog/timer_cmp_irq.sv
verilog/timer_top.sv
tests/timer_assertions.sv
tests/timer_checker.sv
tests/timer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = timer_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST)) common/timer_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/timer_tb.sv ====
// Testbench top for the machine timer
// Generates clk, rtc_clk and reset, reads operations from the case file
// and drives the data bus port, one single-beat access at a time
// All comparing is done in the checker instance

`include "timer_defines.svh"

module timer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    TIMEOUT    = 50;
    localparam string CASE_FILE  = "tests/timer_cases.txt";
    localparam logic [15:0] SEED = 16'd74;

    logic                           clk = 1'b0;
    logic                           rst_n = 1'b0;
    logic                           rtc_clk = 1'b0;
    logic                           rtc_en = 1'b0;
    timer_pkg::mem_req_t            bus_req = '0;
    timer_pkg::mem_rsp_t            bus_rsp;
    logic [2*`TIMER_DWIDTH-1:0]     timer_val;
    logic                           timer_irq;

    logic [15:0]                    lfsr = SEED;
    logic [31:0]                    last_rand = '0;
    logic                           aborted = 1'b0;

    // --------------------------------------------------
    // Clocks with a stoppable RTC
    // --------------------------------------------------
    always #50 clk = ~clk;

    always begin
        #350;
        rtc_clk = rtc_en ? ~rtc_clk : 1'b0;
    end

    timer_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rtc_clk    (rtc_clk),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .timer_val  (timer_val),
        .timer_irq  (timer_irq)
    );

    timer_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .timer_val  (timer_val),
        .timer_irq  (timer_irq)
    );

    // Taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One bit per LFSR step
    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // Single access, returns at the rising edge after the response
    task automatic bus_access(input logic is_wr, input logic [1:0] width,
                              input logic [4:0] ofs, input logic [31:0] data);
        int n;
        @(posedge clk);
        bus_req.req   <= 1'b1;
        bus_req.cmd   <= is_wr ? timer_pkg::MEM_CMD_WR : timer_pkg::MEM_CMD_RD;
        bus_req.width <= timer_pkg::mem_width_e'(width);
        bus_req.addr  <= {27'h0, ofs};
        bus_req.wdata <= data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bus_rsp.req_ack && n < TIMEOUT);
        if (!bus_rsp.req_ack) begin
            $display("Timeout: no req_ack for access at offset %h", ofs);
            aborted = 1'b1;
        end
        @(posedge clk);
        bus_req.req <= 1'b0;
        n = 0;
        // Response is the cycle right after req_ack
        do begin
            @(negedge clk);
            n++;
        end while (bus_rsp.resp == timer_pkg::MEM_RESP_NOTRDY && n < TIMEOUT);
        if (bus_rsp.resp == timer_pkg::MEM_RESP_NOTRDY) begin
            $display("Timeout: no response for access at offset %h", ofs);
            aborted = 1'b1;
        end
        @(posedge clk);
    endtask

    // --------------------------------------------------
    // Case file interpreter
    // --------------------------------------------------
    task automatic run_op(input int op, input logic [4:0] ofs,
                          input logic [31:0] data, input logic [31:0] expv);
        case (op)
            0: bus_access(1'b1, 2'b10, ofs, data);
            1: begin
                bus_access(1'b0, 2'b10, ofs, '0);
                u_checker.check_rsp(timer_pkg::MEM_RESP_RDY_OK, expv, 1'b1);
                // Exact mtime reads are made with time frozen and timer_val must agree
                if (ofs == `TIMER_OFS_MTIMELO || ofs == `TIMER_OFS_MTIMEHI) begin
                    u_checker.check_val_half(ofs == `TIMER_OFS_MTIMEHI, expv);
                end
            end
            2: repeat (data) @(posedge clk);
            3: rtc_en = data[0];
            4: begin
                @(negedge clk);
                u_checker.check_irq(expv[0]);
            end
            5: begin
                draw_word(last_rand);
                bus_access(1'b1, 2'b10, ofs, last_rand);
            end
            6: begin
                bus_access(1'b0, 2'b10, ofs, '0);
                u_checker.check_rsp(timer_pkg::MEM_RESP_RDY_OK, last_rand & expv, 1'b1);
            end
            7, 8, 10: begin
                bus_access(1'b0, 2'b10, ofs, '0);
                u_checker.check_rsp(timer_pkg::MEM_RESP_RDY_OK, '0, 1'b0);
                if (op == 7) u_checker.mark_base();
                else if (op == 8) u_checker.check_delta(data, expv);
                else u_checker.check_abs(data, expv);
            end
            9: begin
                // Bad write with the width code in the data column
                bus_access(1'b1, data[1:0], ofs, 32'hffff_ffff);
                u_checker.check_rsp(timer_pkg::MEM_RESP_ERROR, '0, 1'b1);
            end
            default: begin
                $display("Unknown operation %0d in case file", op);
                aborted = 1'b1;
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          cnt;
        int          op;
        int          tnum;
        int          cur_test;
        logic [31:0] ofs;
        logic [31:0] data;
        logic [31:0] expv;
        string       line;
        cur_test = -1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.len() > 1 && line[0] != 8'h23) begin
                cnt = $sscanf(line, "%h %h %h %h %d", op, ofs, data, expv, tnum);
                if (cnt == 5) begin
                    if (tnum != cur_test && cur_test >= 0) u_checker.end_test(cur_test);
                    cur_test = tnum;
                    run_op(op, ofs[4:0], data, expv);
                end
            end
        end
        if (cur_test >= 0) u_checker.end_test(cur_test);
        u_checker.report();
        if (aborted || u_checker.fail_total() != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// ==== tests/timer_checker.sv ====
// Response and interrupt checker for the machine timer testbench
// Captures every bus response, tracks its own mtimecmp and interrupt
// model from the accesses it sees, and keeps per-test and total counts

module timer_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  timer_pkg::mem_req_t     bus_req,
    input  timer_pkg::mem_rsp_t     bus_rsp,
    input  logic [63:0]             timer_val,
    input  logic                    timer_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0]     last_resp = '0;
    logic [31:0]    last_rdata = '0;
    logic [63:0]    last_val = '0;
    logic [31:0]    base = '0;
    logic [63:0]    cmp_m;
    logic           irq_m;
    logic           pred_ok;
    int             checks = 0;
    int             errs = 0;
    int             checks_all = 0;
    int             errs_all = 0;
    int             tests = 0;

    // --------------------------------------------------
    // Response capture and interrupt model
    // --------------------------------------------------
    always @(negedge clk) begin
        logic        cmp_wr;
        logic [63:0] cmp_new;
        if (!rst_n) begin
            cmp_m   = '0;
            irq_m   = 1'b0;
            pred_ok = 1'b0;
        end else begin
            if (bus_rsp.resp != timer_pkg::MEM_RESP_NOTRDY) begin
                last_resp  = bus_rsp.resp;
                last_rdata = bus_rsp.rdata;
                last_val   = timer_val;
            end
            if (pred_ok) begin
                checks++;
                if (timer_irq !== irq_m) begin
                    $display("CHECK FAILED timer_irq got %h exp %h", timer_irq, irq_m);
                    errs++;
                end
            end
            // Accepted word write to an mtimecmp half
            cmp_new = cmp_m;
            cmp_wr  = bus_rsp.req_ack && bus_req.req && bus_req.cmd == timer_pkg::MEM_CMD_WR
                   && bus_req.width == timer_pkg::MEM_WIDTH_WORD;
            if (cmp_wr && bus_req.addr[4:0] == 5'h10) cmp_new[31:0] = bus_req.wdata;
            else if (cmp_wr && bus_req.addr[4:0] == 5'h14) cmp_new[63:32] = bus_req.wdata;
            else cmp_wr = 1'b0;
            if (!irq_m || cmp_wr) irq_m = timer_val >= cmp_new;
            cmp_m   = cmp_new;
            pred_ok = 1'b1;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h exp %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_rsp(input logic [1:0] exp_resp, input logic [31:0] exp_data,
                             input logic with_data);
        compare("bus_rsp.resp", {30'h0, last_resp}, {30'h0, exp_resp});
        if (with_data) compare("bus_rsp.rdata", last_rdata, exp_data);
    endtask

    // Live time output at the last response against an expected half
    task automatic check_val_half(input logic hi, input logic [31:0] exp);
        if (hi) begin
            compare("timer_val[63:32]", last_val[63:32], exp);
        end else begin
            compare("timer_val[31:0]", last_val[31:0], exp);
        end
    endtask

    task automatic check_irq(input logic exp);
        compare("timer_irq", {31'h0, timer_irq}, {31'h0, exp});
    endtask

    task automatic mark_base();
        base = last_rdata;
    endtask

    // Growth since the mark must lie in lo..hi
    task automatic check_delta(input logic [31:0] lo, input logic [31:0] hi);
        logic [31:0] d;
        d = last_rdata - base;
        checks++;
        if (d < lo || d > hi) begin
            $display("CHECK FAILED mtime delta got %h exp %h..%h", d, lo, hi);
            errs++;
        end
    endtask

    task automatic check_abs(input logic [31:0] lo, input logic [31:0] hi);
        checks++;
        if (last_rdata < lo || last_rdata > hi) begin
            $display("CHECK FAILED bus_rsp.rdata got %h exp %h..%h", last_rdata, lo, hi);
            errs++;
        end
    endtask

    task automatic end_test(input int n);
        $display("Test %0d %s, %0d checks, %0d errors", n, errs == 0 ? "ok" : "failed",
                 checks, errs);
        checks_all += checks;
        errs_all   += errs;
        checks = 0;
        errs = 0;
        tests++;
    endtask

    task automatic report();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks_all + checks,
                 errs_all + errs);
    endtask

    function automatic int fail_total();
        return errs_all + errs;
    endfunction

endmodule

// ==== tests/timer_assertions.sv ====
// Bus and interrupt properties for the machine timer
// Bound into every timer_top instance

module timer_assertions (
    input  logic                    clk,
    input  logic                    rst_n,
    input  timer_pkg::mem_rsp_t     bus_rsp,
    input  timer_pkg::timer_wr_t    wr,
    input  logic                    timer_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    // No back-to-back acknowledge
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.req_ack |=> !bus_rsp.req_ack)
        else $error("req_ack high two cycles in a row");

    // Every acknowledge gets a response one cycle later
    ack_resp: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.req_ack |=> bus_rsp.resp != timer_pkg::MEM_RESP_NOTRDY)
        else $error("no response after req_ack");

    // Sticky interrupt only drops through an mtimecmp write
    irq_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(timer_irq) |-> $past(wr.cmp_lo | wr.cmp_hi))
        else $error("timer_irq fell without an mtimecmp write");

endmodule

bind timer_top timer_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_rsp    (bus_rsp),
    .wr         (wr),
    .timer_irq  (timer_irq)
);

// ==== verilog/timer_top.sv ====
// Machine timer top level
// Connects the data bus port to the register control block and the
// tick, mtime and compare datapath blocks
// timer_val carries the live mtime value to the core

`include "timer_defines.svh"

module timer_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rtc_clk,

    // Core data port
    input  timer_pkg::mem_req_t             bus_req,
    output timer_pkg::mem_rsp_t             bus_rsp,

    // Time value and interrupt to the core
    output logic [2*`TIMER_DWIDTH-1:0]      timer_val,
    output logic                            timer_irq
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    timer_pkg::timer_cfg_t                  cfg;
    timer_pkg::timer_wr_t                   wr;
    logic                                   tick;
    logic [2*`TIMER_DWIDTH-1:0]             mtimecmp;

    // Bus decode, CONTROL and DIVIDER, read mux
    timer_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .mtime      (timer_val),
        .mtimecmp   (mtimecmp),
        .cfg        (cfg),
        .wr         (wr)
    );

    // Tick pulse from divided clk or RTC
    timer_tick_gen u_tick_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .rtc_clk    (rtc_clk),
        .cfg        (cfg),
        .wr         (wr),
        .tick       (tick)
    );

    // Running time counter, also the timer_val output
    timer_mtime u_mtime (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .wr         (wr),
        .mtime      (timer_val)
    );

    // Compare register and interrupt
    timer_cmp_irq u_cmp_irq (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .mtime      (timer_val),
        .mtimecmp   (mtimecmp),
        .timer_irq  (timer_irq)
    );

endmodule

// ==== verilog/timer_cmp_irq.sv ====
// mtimecmp register and the machine timer interrupt
// The interrupt is sticky and only re-evaluated on an mtimecmp write,
// which compares against the value being written

`include "timer_defines.svh"

module timer_cmp_irq (
    input  logic                            clk,
    input  logic                            rst_n,
    input  timer_pkg::timer_wr_t            wr,
    input  logic [2*`TIMER_DWIDTH-1:0]      mtime,
    output logic [2*`TIMER_DWIDTH-1:0]      mtimecmp,
    output logic                            timer_irq
);

    localparam int unsigned DW = `TIMER_DWIDTH;

    logic [2*DW-1:0]    cmp_q;
    logic [2*DW-1:0]    cmp_new;
    logic               cmp_wr;
    logic               cmp_hit;

    assign cmp_wr = wr.cmp_lo | wr.cmp_hi;

    // Merge the written half
    always_comb begin
        cmp_new = cmp_q;
        if (wr.cmp_lo) begin
            cmp_new[DW-1:0] = wr.wdata;
        end
        if (wr.cmp_hi) begin
            cmp_new[2*DW-1:DW] = wr.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_q <= '0;
        end else if (cmp_wr) begin
            cmp_q <= cmp_new;
        end
    end

    // Compare with the incoming value in a write cycle
    assign cmp_hit = mtime >= cmp_new;

    // Set on hit, cleared only through a compare write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else if (!timer_irq || cmp_wr) begin
            timer_irq <= cmp_hit;
        end
    end

    assign mtimecmp = cmp_q;

endmodule

// ==== verilog/timer_mtime.sv ====
// mtime counter of the machine timer
// Advances by one on each tick, software may replace either half
// Increment is split into two 32-bit halves to shorten the carry path

`include "timer_defines.svh"

module timer_mtime (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tick,
    input  timer_pkg::timer_wr_t            wr,
    output logic [2*`TIMER_DWIDTH-1:0]      mtime
);

    localparam int unsigned DW = `TIMER_DWIDTH;

    logic [DW-1:0]  lo_q;
    logic [DW-1:0]  hi_q;
    logic           lo_carry;

    // Low half wraps on this tick
    assign lo_carry = tick & (&lo_q);

    // --------------------------------------------------
    // Low half
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lo_q <= '0;
        end else if (wr.mtime_lo) begin
            lo_q <= wr.wdata;
        end else if (tick) begin
            lo_q <= lo_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // High half
    // --------------------------------------------------
    // Software write beats the carry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi_q <= '0;
        end else if (wr.mtime_hi) begin
            hi_q <= wr.wdata;
        end else if (lo_carry) begin
            hi_q <= hi_q + 1'b1;
        end
    end

    assign mtime = {hi_q, lo_q};

endmodule

// ==== verilog/timer_tick_gen.sv ====
// Tick generator for the machine timer
// Source is clk or the external rtc_clk, selected by CONTROL
// The enabled source decrements a down-counter, tick fires at zero

`include "timer_defines.svh"

module timer_tick_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rtc_clk,
    input  timer_pkg::timer_cfg_t   cfg,
    input  timer_pkg::timer_wr_t    wr,
    output logic                    tick
);

    logic                           rtc_tgl;
    logic [2:0]                     rtc_sync;
    logic                           rtc_pulse;
    logic                           cnt_en;
    logic [`TIMER_DIV_WIDTH-1:0]    cnt;

    // --------------------------------------------------
    // RTC crossing
    // --------------------------------------------------
    // Toggles once per rtc_clk edge while selected
    always_ff @(posedge rtc_clk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_tgl <= 1'b0;
        end else if (cfg.clksrc_rtc) begin
            rtc_tgl <= ~rtc_tgl;
        end
    end

    // Three-flop chain into clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_sync <= '0;
        end else begin
            rtc_sync <= {rtc_sync[1:0], rtc_tgl};
        end
    end

    // One clk cycle per RTC edge
    assign rtc_pulse = rtc_sync[2] ^ rtc_sync[1];

    // --------------------------------------------------
    // Divider
    // --------------------------------------------------
    assign cnt_en = (cfg.clksrc_rtc ? rtc_pulse : 1'b1) & cfg.en;
    assign tick   = cnt_en & (cnt == '0);

    // DIVIDER write wins, then reload on tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (wr.divider) begin
            cnt <= wr.wdata[`TIMER_DIV_WIDTH-1:0];
        end else if (tick) begin
            cnt <= cfg.div;
        end else if (cnt_en) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== timer_ctrl/timer_ctrl.sv ====
// Bus side of the machine timer
// Registers each request, checks width, alignment and offset, then
// either strobes one register write or returns read data
// Request in at N, req_ack after N+1, response after N+2
// Unsupported accesses get an ERROR response with zero data

`include "timer_defines.svh"

module timer_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,

    input  timer_pkg::mem_req_t             bus_req,
    output timer_pkg::mem_rsp_t             bus_rsp,

    input  logic [2*`TIMER_DWIDTH-1:0]      mtime,
    input  logic [2*`TIMER_DWIDTH-1:0]      mtimecmp,

    output timer_pkg::timer_cfg_t           cfg,
    output timer_pkg::timer_wr_t            wr
);

    // CONTROL bit positions
    localparam int unsigned CTRL_EN_BIT     = 0;
    localparam int unsigned CTRL_CLKSRC_BIT = 1;

    localparam int unsigned DW = `TIMER_DWIDTH;
    localparam int unsigned OW = `TIMER_REG_AWIDTH;

    // Input stage
    logic                       in_req;
    timer_pkg::mem_cmd_e        in_cmd;
    timer_pkg::mem_width_e      in_width;
    logic [OW-1:0]              in_ofs;
    logic [DW-1:0]              in_wdata;
    logic                       in_ok;
    logic                       accept;

    // Accepted access held while req_ack is high
    logic                       acc_ok;
    timer_pkg::mem_cmd_e        acc_cmd;
    logic [OW-1:0]              acc_ofs;
    logic [DW-1:0]              acc_wdata;
    logic                       acc_wr;

    logic                       ctrl_wr;
    logic [DW-1:0]              rd_data;
    timer_pkg::mem_rsp_t        rsp_q;
    timer_pkg::timer_cfg_t      cfg_q;

    // --------------------------------------------------
    // Request capture and check
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_req <= 1'b0;
        end else begin
            in_req <= bus_req.req;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        in_cmd   <= bus_req.cmd;
        in_width <= bus_req.width;
        in_ofs   <= bus_req.addr[OW-1:0];
        in_wdata <= bus_req.wdata;
    end

    // Word only, aligned, within the six registers
    assign in_ok = (in_width == timer_pkg::MEM_WIDTH_WORD)
                 & (in_ofs[1:0] == 2'b00)
                 & (in_ofs <= `TIMER_OFS_MTIMECMPHI);

    // Held req is ignored during ack and response cycles
    assign accept = in_req & ~rsp_q.req_ack & (rsp_q.resp == timer_pkg::MEM_RESP_NOTRDY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_ok <= 1'b0;
        end else if (accept) begin
            acc_ok <= in_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_cmd   <= in_cmd;
            acc_ofs   <= in_ofs;
            acc_wdata <= in_wdata;
        end
    end

    // --------------------------------------------------
    // Write strobes
    // --------------------------------------------------
    assign acc_wr = rsp_q.req_ack & acc_ok & (acc_cmd == timer_pkg::MEM_CMD_WR);

    always_comb begin
        ctrl_wr  = 1'b0;
        wr       = '0;
        wr.wdata = acc_wdata;
        if (acc_wr) begin
            case (acc_ofs)
                `TIMER_OFS_CONTROL:    ctrl_wr     = 1'b1;
                `TIMER_OFS_DIVIDER:    wr.divider  = 1'b1;
                `TIMER_OFS_MTIMELO:    wr.mtime_lo = 1'b1;
                `TIMER_OFS_MTIMEHI:    wr.mtime_hi = 1'b1;
                `TIMER_OFS_MTIMECMPLO: wr.cmp_lo   = 1'b1;
                `TIMER_OFS_MTIMECMPHI: wr.cmp_hi   = 1'b1;
                default: ;
            endcase
        end
    end

    // CONTROL and DIVIDER registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.en         <= 1'b1;
            cfg_q.clksrc_rtc <= 1'b0;
            cfg_q.div        <= '0;
        end else begin
            if (ctrl_wr) begin
                cfg_q.en         <= acc_wdata[CTRL_EN_BIT];
                cfg_q.clksrc_rtc <= acc_wdata[CTRL_CLKSRC_BIT];
            end
            if (wr.divider) begin
                cfg_q.div <= acc_wdata[`TIMER_DIV_WIDTH-1:0];
            end
        end
    end

    assign cfg = cfg_q;

    // --------------------------------------------------
    // Read mux and response
    // --------------------------------------------------
    always_comb begin
        case (acc_ofs)
            `TIMER_OFS_CONTROL:    rd_data = DW'({cfg_q.clksrc_rtc, cfg_q.en});
            `TIMER_OFS_DIVIDER:    rd_data = DW'(cfg_q.div);
            `TIMER_OFS_MTIMELO:    rd_data = mtime[DW-1:0];
            `TIMER_OFS_MTIMEHI:    rd_data = mtime[2*DW-1:DW];
            `TIMER_OFS_MTIMECMPLO: rd_data = mtimecmp[DW-1:0];
            `TIMER_OFS_MTIMECMPHI: rd_data = mtimecmp[2*DW-1:DW];
            default:               rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q.req_ack <= 1'b0;
            rsp_q.resp    <= timer_pkg::MEM_RESP_NOTRDY;
            rsp_q.rdata   <= '0;
        end else begin
            rsp_q.req_ack <= accept;
            if (rsp_q.req_ack) begin
                rsp_q.resp  <= acc_ok ? timer_pkg::MEM_RESP_RDY_OK : timer_pkg::MEM_RESP_ERROR;
                // Data only for a good read
                rsp_q.rdata <= (acc_ok && acc_cmd == timer_pkg::MEM_CMD_RD) ? rd_data : '0;
            end else begin
                rsp_q.resp  <= timer_pkg::MEM_RESP_NOTRDY;
                rsp_q.rdata <= '0;
            end
        end
    end

    assign bus_rsp = rsp_q;

endmodule

// ==== common/timer_pkg.sv ====
// Shared types for the machine timer
// Bus encodings of the core data port and the structs passed between blocks

`include "timer_defines.svh"

package timer_pkg;

    // Data port command
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access width of which only WORD is served
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Single-cycle response code
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_ERROR  = 2'b10
    } mem_resp_e;

    // Request from the core held until req_ack
    typedef struct packed {
        logic                       req;
        mem_cmd_e                   cmd;
        mem_width_e                 width;
        logic [`TIMER_AWIDTH-1:0]   addr;
        logic [`TIMER_DWIDTH-1:0]   wdata;
    } mem_req_t;

    // Response back to the core
    typedef struct packed {
        logic                       req_ack;
        mem_resp_e                  resp;
        logic [`TIMER_DWIDTH-1:0]   rdata;
    } mem_rsp_t;

    // Tick source configuration from CONTROL and DIVIDER
    typedef struct packed {
        logic                           en;
        logic                           clksrc_rtc;
        logic [`TIMER_DIV_WIDTH-1:0]    div;
    } timer_cfg_t;

    // One-cycle write strobes with shared write data
    typedef struct packed {
        logic                       mtime_lo;
        logic                       mtime_hi;
        logic                       cmp_lo;
        logic                       cmp_hi;
        logic                       divider;
        logic [`TIMER_DWIDTH-1:0]   wdata;
    } timer_wr_t;

endpackage

// ==== common/timer_defines.svh ====
// Width and register map macros for the machine timer
// Included by the timer package and by every timer RTL module

`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// Data bus port widths
`define TIMER_DWIDTH            32
`define TIMER_AWIDTH            32

// Register offset field and tick divider width
`define TIMER_REG_AWIDTH        5
`define TIMER_DIV_WIDTH         10

// Register map as byte offsets within the timer window
`define TIMER_OFS_CONTROL       5'h00
`define TIMER_OFS_DIVIDER       5'h04
`define TIMER_OFS_MTIMELO       5'h08
`define TIMER_OFS_MTIMEHI       5'h0C
`define TIMER_OFS_MTIMECMPLO    5'h10
`define TIMER_OFS_MTIMECMPHI    5'h14

`endif
